// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fetch
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Block and slot geometry
    localparam int FETCH_WIDTH = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LINE_WIDTH = 128;
    localparam int WORDS_PER_LINE = LINE_WIDTH / DATA_WIDTH;

    // Fetch target queue
    localparam int FTQ_DEPTH = 4;
    localparam int FTQ_PTR_WIDTH = $clog2(FTQ_DEPTH);

    // 1 KiB instruction store
    localparam int ICACHE_WORDS = 256;
    localparam int ICACHE_IDX_WIDTH = $clog2(ICACHE_WORDS);

    localparam int LEN_WIDTH = $clog2(FETCH_WIDTH + 1);  // Holds 0 to 4

    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUNNING
    } fetch_state_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_pc;
        logic                  is_cross_line;  // Block spills into the next line
        logic [LEN_WIDTH-1:0]  length;
    } ftq_entry_t;

endpackage

`default_nettype wire

// File: logic/fetch_target_queue.sv
`default_nettype none

module fetch_target_queue (
    input wire                             clk,
    input wire                             rst,
    input wire                             redirect_i,
    input wire [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
    ftq_ifu_if.queue                       ftq_o
);

    fetch_pkg::fetch_state_e state_q;
    logic [fetch_pkg::ADDR_WIDTH-1:0] pc_q;
    logic [fetch_pkg::ADDR_WIDTH-1:0] gen_pc;
    logic [fetch_pkg::ADDR_WIDTH-1:0] next_pc;
    logic [3:0] words_left;
    logic [3:0] end_word;
    fetch_pkg::ftq_entry_t gen_entry;
    fetch_pkg::ftq_entry_t ftq_mem [fetch_pkg::FTQ_DEPTH];
    fetch_pkg::ftq_entry_t head;
    logic [fetch_pkg::FTQ_PTR_WIDTH:0] wr_ptr_q;
    logic [fetch_pkg::FTQ_PTR_WIDTH:0] rd_ptr_q;
    logic [fetch_pkg::FTQ_PTR_WIDTH:0] count;
    logic full;
    logic empty;
    logic push;
    logic pop;

    // Redirect pc goes straight into the first block
    assign gen_pc = redirect_i ? {redirect_pc_i[fetch_pkg::ADDR_WIDTH-1:2], 2'b00} : pc_q;
    assign words_left = 4'd8 - {1'b0, gen_pc[4:2]};  // Up to the next 32-byte boundary

    always_comb begin
        gen_entry.start_pc = gen_pc;
        if (words_left > 4'(fetch_pkg::FETCH_WIDTH)) begin
            gen_entry.length = fetch_pkg::FETCH_WIDTH[fetch_pkg::LEN_WIDTH-1:0];
        end else begin
            gen_entry.length = words_left[fetch_pkg::LEN_WIDTH-1:0];
        end
        end_word = {2'b00, gen_pc[3:2]} + {1'b0, gen_entry.length};
        gen_entry.is_cross_line = end_word > 4'(fetch_pkg::WORDS_PER_LINE);
    end

    assign next_pc = gen_pc + {gen_entry.length, 2'b00};

    assign count = wr_ptr_q - rd_ptr_q;
    assign full  = count == fetch_pkg::FTQ_DEPTH;
    assign empty = count == '0;
    assign push  = redirect_i | ((state_q == fetch_pkg::FETCH_RUNNING) & ~full);
    assign pop   = ftq_o.valid & ftq_o.accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= fetch_pkg::FETCH_IDLE;
            pc_q     <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (redirect_i) begin
            // Flush and restart with the new block in entry 0
            state_q  <= fetch_pkg::FETCH_RUNNING;
            pc_q     <= next_pc;
            wr_ptr_q <= 1;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                pc_q     <= next_pc;
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ftq_mem[redirect_i ? '0 : wr_ptr_q[fetch_pkg::FTQ_PTR_WIDTH-1:0]] <= gen_entry;
        end
    end

    assign head                = ftq_mem[rd_ptr_q[fetch_pkg::FTQ_PTR_WIDTH-1:0]];
    assign ftq_o.valid         = ~empty;
    assign ftq_o.start_pc      = head.start_pc;
    assign ftq_o.is_cross_line = head.is_cross_line;
    assign ftq_o.length        = head.length;

    // Never more entries than the queue holds
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        count <= fetch_pkg::FTQ_DEPTH);

    // The fetch unit only takes an entry that exists
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        ftq_o.accept |-> ~empty);

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`default_nettype none

module fetch_top (
    input wire                             clk,
    input wire                             rst,
    input wire                             redirect_i,
    input wire [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
    input wire                             stall_i,
    output wire [fetch_pkg::FETCH_WIDTH-1:0]                       slot_valid_o,
    output wire [fetch_pkg::FETCH_WIDTH*fetch_pkg::ADDR_WIDTH-1:0] slot_pc_o,
    output wire [fetch_pkg::FETCH_WIDTH*fetch_pkg::DATA_WIDTH-1:0] slot_instr_o,
    output wire [fetch_pkg::FETCH_WIDTH-1:0]                       slot_last_o
);

    ftq_ifu_if   u_ftq_if ();
    icache_rd_if u_icache_if ();

    fetch_target_queue u_ftq (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .ftq_o         (u_ftq_if)
    );

    // Redirect doubles as the flush; slot k sits at bits [k*32 +: 32]
    ifu u_ifu (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),
        .stall_i      (stall_i),
        .ftq_i        (u_ftq_if),
        .icache_o     (u_icache_if),
        .slot_valid_o (slot_valid_o),
        .slot_pc_o    (slot_pc_o),
        .slot_instr_o (slot_instr_o),
        .slot_last_o  (slot_last_o)
    );

    icache_model u_icache (
        .clk  (clk),
        .rst  (rst),
        .rd_i (u_icache_if)
    );

endmodule

`default_nettype wire

// File: logic/ftq_ifu_if.sv
`default_nettype none

interface ftq_ifu_if;

    logic                             valid;
    logic [fetch_pkg::ADDR_WIDTH-1:0] start_pc;
    logic                             is_cross_line;
    logic [fetch_pkg::LEN_WIDTH-1:0]  length;
    logic                             accept;  // Same cycle as valid

    modport queue (
        output valid, start_pc, is_cross_line, length,
        input  accept
    );

    modport ifu (
        input  valid, start_pc, is_cross_line, length,
        output accept
    );

endinterface

`default_nettype wire

// File: logic/icache_model.sv
`default_nettype none

module icache_model (
    input wire          clk,
    input wire          rst,
    icache_rd_if.cache  rd_i
);

    logic [fetch_pkg::DATA_WIDTH-1:0] mem [fetch_pkg::ICACHE_WORDS];
    logic [1:0][fetch_pkg::WORDS_PER_LINE-1:0][fetch_pkg::DATA_WIDTH-1:0] line_rd;
    logic                             port1_valid_q;  // Extra stage on port 1
    logic [fetch_pkg::LINE_WIDTH-1:0] port1_data_q;

    // Line index wraps at 1 KiB
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            for (int w = 0; w < fetch_pkg::WORDS_PER_LINE; w++) begin
                line_rd[p][w] = mem[{rd_i.raddr[p][fetch_pkg::ICACHE_IDX_WIDTH+1:4], w[1:0]}];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fetch_pkg::ICACHE_WORDS; i++) begin
                mem[i] <= ~{i[fetch_pkg::DATA_WIDTH-3:0], 2'b00};  // Complement of byte address
            end
            rd_i.rvalid   <= '0;
            port1_valid_q <= 1'b0;
        end else begin
            rd_i.rvalid   <= {port1_valid_q, rd_i.rreq[0]};
            port1_valid_q <= rd_i.rreq[1];
        end
    end

    always_ff @(posedge clk) begin
        rd_i.rdata[0] <= line_rd[0];
        port1_data_q  <= line_rd[1];
        rd_i.rdata[1] <= port1_data_q;
    end

    // Requests always come line aligned from the fetch unit
    a_port0_aligned: assert property (@(posedge clk) disable iff (rst)
        rd_i.rreq[0] |-> rd_i.raddr[0][3:0] == 4'b0000);
    a_port1_aligned: assert property (@(posedge clk) disable iff (rst)
        rd_i.rreq[1] |-> rd_i.raddr[1][3:0] == 4'b0000);

endmodule

`default_nettype wire

// File: logic/icache_rd_if.sv
`default_nettype none

interface icache_rd_if;

    // Port 1 only used for the second line of a cross-line block
    logic [1:0]                                   rreq;
    logic [1:0][fetch_pkg::ADDR_WIDTH-1:0] raddr;
    logic [1:0]                                   rvalid;
    logic [1:0][fetch_pkg::LINE_WIDTH-1:0] rdata;

    modport ifu (
        output rreq, raddr,
        input  rvalid, rdata
    );

    modport cache (
        input  rreq, raddr,
        output rvalid, rdata
    );

endinterface

`default_nettype wire

// File: logic/ifu.sv
`default_nettype none

module ifu (
    input wire        clk,
    input wire        rst,
    input wire        flush_i,
    input wire        stall_i,  // Instruction buffer full
    ftq_ifu_if.ifu    ftq_i,
    icache_rd_if.ifu  icache_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                            slot_valid_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::ADDR_WIDTH-1:0] slot_pc_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0][fetch_pkg::DATA_WIDTH-1:0] slot_instr_o,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                            slot_last_o
);

    logic p0_send;
    logic flushing_q;
    logic flushing;
    logic p1_valid;
    fetch_pkg::ftq_entry_t p1_entry;
    logic [1:0] p1_rvalid_q;
    logic [1:0][fetch_pkg::LINE_WIDTH-1:0] p1_rdata_q;
    logic [1:0] line_present;
    logic p1_read_done;
    logic p1_busy;
    logic [2*fetch_pkg::WORDS_PER_LINE-1:0][fetch_pkg::DATA_WIDTH-1:0] lines;

    // P0 takes a block only when no read is left over
    assign p0_send      = ftq_i.valid & ~flushing & ~stall_i & ~p1_busy;
    assign ftq_i.accept = p0_send;

    always_comb begin
        icache_o.rreq  = '0;
        icache_o.raddr = '0;
        if (p0_send) begin
            icache_o.rreq[0]  = 1'b1;
            icache_o.rreq[1]  = ftq_i.is_cross_line;
            icache_o.raddr[0] = {ftq_i.start_pc[fetch_pkg::ADDR_WIDTH-1:4], 4'b0000};
            if (ftq_i.is_cross_line) begin
                icache_o.raddr[1] = {ftq_i.start_pc[fetch_pkg::ADDR_WIDTH-1:4] + 1'b1, 4'b0000};
            end
        end
    end

    // P1 counts a line as present in the cycle it returns
    assign line_present = icache_o.rvalid | p1_rvalid_q;
    assign p1_read_done = p1_valid & line_present[0] & (line_present[1] | ~p1_entry.is_cross_line);
    assign p1_busy      = p1_valid & ~p1_read_done;

    assign flushing = flushing_q | flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            flushing_q <= 1'b0;
        end else if (flush_i & p1_busy) begin
            flushing_q <= 1'b1;  // Drop the read still in flight
        end else if (p1_read_done) begin
            flushing_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            p1_valid    <= 1'b0;
            p1_rvalid_q <= '0;
        end else if (p0_send) begin
            p1_valid    <= 1'b1;
            p1_rvalid_q <= '0;
        end else if (p1_read_done & (~stall_i | flushing)) begin
            p1_valid    <= 1'b0;
            p1_rvalid_q <= '0;
        end else begin
            p1_rvalid_q <= line_present;  // Wait here under stall
        end
    end

    always_ff @(posedge clk) begin
        if (p0_send) begin
            p1_entry.start_pc      <= ftq_i.start_pc;
            p1_entry.is_cross_line <= ftq_i.is_cross_line;
            p1_entry.length        <= ftq_i.length;
        end
        for (int p = 0; p < 2; p++) begin
            if (icache_o.rvalid[p]) begin
                p1_rdata_q[p] <= icache_o.rdata[p];
            end
        end
    end

    // P2 picks the words out of both lines
    assign lines = {
        icache_o.rvalid[1] ? icache_o.rdata[1] : p1_rdata_q[1],
        icache_o.rvalid[0] ? icache_o.rdata[0] : p1_rdata_q[0]
    };

    always_ff @(posedge clk) begin
        if (rst | flush_i) begin
            slot_valid_o <= '0;
            slot_last_o  <= '0;
        end else if (~stall_i) begin
            for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
                if (p1_read_done & ~flushing_q) begin
                    slot_valid_o[i] <= i[fetch_pkg::LEN_WIDTH-1:0] < p1_entry.length;
                    slot_last_o[i]  <= (i[fetch_pkg::LEN_WIDTH-1:0] + 1'b1) == p1_entry.length;
                end else begin
                    slot_valid_o[i] <= 1'b0;
                    slot_last_o[i]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_i & p1_read_done) begin
            for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
                slot_pc_o[i]    <= p1_entry.start_pc + {i[fetch_pkg::ADDR_WIDTH-3:0], 2'b00};
                slot_instr_o[i] <= lines[{1'b0, p1_entry.start_pc[3:2]} + i[2:0]];
            end
        end
    end

    // The first line is back one cycle after the block was taken
    a_line0_returns: assert property (@(posedge clk) disable iff (rst)
        ftq_i.accept |=> icache_o.rvalid[0]);

    // No second accept while a cross-line read is outstanding
    a_no_accept_in_flight: assert property (@(posedge clk) disable iff (rst)
        ftq_i.accept & ftq_i.is_cross_line |=> ~ftq_i.accept);

endmodule

`default_nettype wire

// File: project.f
logic/fetch_pkg.sv
logic/ftq_ifu_if.sv
logic/icache_rd_if.sv
logic/fetch_target_queue.sv
logic/ifu.sv
logic/icache_model.sv
logic/fetch_top.sv
test/tb_fetch.sv

// File: test/tb_fetch.sv
`default_nettype none

module tb_fetch;

    logic         clk;
    logic         rst;
    logic         redirect_i;
    logic [31:0]  redirect_pc_i;
    logic         stall_i;
    logic [3:0]   slot_valid_o;
    logic [127:0] slot_pc_o;
    logic [127:0] slot_instr_o;
    logic [3:0]   slot_last_o;

    logic [31:0] lfsr_q;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          blocks_at_start;
    string       test_name;

    // Reference model of the expected stream
    logic        started_q;
    logic [31:0] exp_pc_q;
    int          blocks_seen;
    int          words_left;
    int          exp_len;
    logic [3:0]  exp_valid;
    logic [3:0]  exp_last;
    logic [31:0] exp_slot_pc [4];
    logic [31:0] exp_slot_instr [4];
    logic        consume;

    fetch_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .stall_i       (stall_i),
        .slot_valid_o  (slot_valid_o),
        .slot_pc_o     (slot_pc_o),
        .slot_instr_o  (slot_instr_o),
        .slot_last_o   (slot_last_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_problem(string what);
        errors++;
        $display("Problem in %s: %s", test_name, what);
    endtask

    // Expected block at the expected pc
    always_comb begin
        words_left = (32 - int'(exp_pc_q[4:0])) / 4;  // Words up to the next 32-byte boundary
        exp_len    = (words_left < 4) ? words_left : 4;
        exp_valid  = '0;
        exp_last   = '0;
        for (int k = 0; k < 4; k++) begin
            exp_slot_pc[k]    = exp_pc_q + 32'(4 * k);
            exp_slot_instr[k] = ~(exp_slot_pc[k] & 32'h0000_03ff);  // Complemented byte address
            exp_valid[k]      = k < exp_len;
            exp_last[k]       = (k + 1) == exp_len;
        end
    end

    assign consume = ~stall_i & (|slot_valid_o);  // Buffer takes the slots

    always @(posedge clk) begin
        if (rst) begin
            started_q   <= 1'b0;
            exp_pc_q    <= '0;
            blocks_seen <= 0;
        end else begin
            if (consume) begin
                blocks_seen <= blocks_seen + 1;
            end
            if (redirect_i) begin
                started_q <= 1'b1;
                exp_pc_q  <= {redirect_pc_i[31:2], 2'b00};
            end else if (consume) begin
                exp_pc_q <= exp_pc_q + 32'(4 * exp_len);
            end
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (rst)
        ~started_q |-> slot_valid_o == '0)
        else report_mismatch("slot_valid before redirect", 32'h0, {28'b0, $sampled(slot_valid_o)});

    a_valid_mask: assert property (@(posedge clk) disable iff (rst)
        consume |-> slot_valid_o == exp_valid)
        else report_mismatch("slot_valid", {28'b0, $sampled(exp_valid)},
                             {28'b0, $sampled(slot_valid_o)});

    a_last_flag: assert property (@(posedge clk) disable iff (rst)
        consume |-> slot_last_o == exp_last)
        else report_mismatch("slot_last", {28'b0, $sampled(exp_last)},
                             {28'b0, $sampled(slot_last_o)});

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall_i & ~redirect_i |=> $stable(slot_valid_o) && $stable(slot_last_o)
            && (slot_valid_o == '0 || ($stable(slot_pc_o) && $stable(slot_instr_o))))
        else report_problem("slot outputs changed while stall_i was high");

    for (genvar k = 0; k < 4; k++) begin : g_slot
        logic [31:0] pc_k;
        logic [31:0] instr_k;

        assign pc_k    = slot_pc_o[k*32 +: 32];
        assign instr_k = slot_instr_o[k*32 +: 32];

        a_slot_pc: assert property (@(posedge clk) disable iff (rst)
            consume & slot_valid_o[k] |-> pc_k == exp_slot_pc[k])
            else report_mismatch($sformatf("slot %0d pc", k), $sampled(exp_slot_pc[k]),
                                 $sampled(pc_k));

        a_slot_instr: assert property (@(posedge clk) disable iff (rst)
            consume & slot_valid_o[k] |-> instr_k == exp_slot_instr[k])
            else report_mismatch($sformatf("slot %0d instr", k), $sampled(exp_slot_instr[k]),
                                 $sampled(instr_k));
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic redirect_to(logic [31:0] pc);
        redirect_i    = 1'b1;
        redirect_pc_i = pc;
        next_cycle();
        redirect_i    = 1'b0;
    endtask

    // Wait for n blocks to reach the buffer, optionally under random stalls
    task automatic run_blocks(int n, bit random_stall);
        int target;
        int cycles;
        int limit;
        target = blocks_seen + n;
        cycles = 0;
        limit  = n * 40 + 20;  // Generous even at heavy stall
        while (blocks_seen < target && cycles < limit) begin
            stall_i = random_stall ? lfsr_step() : 1'b0;
            next_cycle();
            cycles++;
        end
        stall_i = 1'b0;
        if (blocks_seen < target) begin
            report_problem($sformatf("only %0d of %0d blocks arrived within %0d cycles",
                                     n - (target - blocks_seen), n, limit));
        end
    endtask

    task automatic begin_test(string name);
        test_name       = name;
        errors_at_start = errors;
        blocks_at_start = blocks_seen;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("%-12s %0d blocks checked, %0d errors", test_name,
                 blocks_seen - blocks_at_start, errors - errors_at_start);
    endtask

    initial begin
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        stall_i       = 1'b0;
        lfsr_q        = 32'h1702_a8c3;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_name     = "reset";
        repeat (10) next_cycle();
        rst = 1'b0;

        begin_test("reset");
        repeat (20) begin
            stall_i = lfsr_step();  // No redirect yet, so no output
            next_cycle();
        end
        stall_i = 1'b0;
        end_test();

        // Runs across the 1 KiB wrap of the store
        begin_test("aligned");
        redirect_to(32'h0000_03c0);
        run_blocks(12, 1'b0);
        end_test();

        begin_test("unaligned");
        repeat (8) begin
            redirect_to(random_bits(32) & 32'hffff_fffc);
            run_blocks(3, 1'b0);
        end
        end_test();

        begin_test("stall");
        redirect_to(random_bits(32) & 32'hffff_fffc);
        run_blocks(20, 1'b1);
        end_test();

        begin_test("redirect");
        redirect_to(32'h0000_0208);  // Cross-line first block
        next_cycle();
        redirect_to(32'h0000_0054);  // Port 1 still outstanding here
        run_blocks(4, 1'b0);
        repeat (6) begin
            redirect_to(random_bits(32) & 32'hffff_fffc);
            repeat (random_bits(3)) begin
                stall_i = lfsr_step();
                next_cycle();
            end
            redirect_to(random_bits(32) & 32'hffff_fffc);
            run_blocks(3, 1'b1);
        end
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
